// ==== src/fetch_settings.svh ====
/*
 * sizes and reset address of the fetch frontend
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// fetch fifo depth, power of two
`define FETCH_FIFO_DEPTH 4
// instruction memory size in 32-bit words
`define IMEM_WORDS 64
// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== src/fetch_pkg.sv ====
/*
 * fetch frontend types: address, instruction, exception, prediction,
 * fifo entry and the branch view of an instruction word
 */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // b-type layout, msb first
    typedef struct packed {
        logic       sign;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } branch_fields_t;

    // same word, raw or as branch fields
    typedef union packed {
        instr_t         raw;
        branch_fields_t branch;
    } instr_view_u;

    typedef struct packed {
        logic       valid;
        logic [1:0] cause;
    } exception_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } branchpredict_t;

    typedef struct packed {
        addr_t          addr;
        instr_t         instr;
        branchpredict_t bp;
        exception_t     ex;
    } fetch_entry_t;

    localparam logic [6:0] OPCODE_BRANCH      = 7'b1100011;
    localparam logic [1:0] CAUSE_ACCESS_FAULT = 2'd1;

endpackage

`default_nettype wire

// ==== src/imem_bus_if.sv ====
/*
 * one instruction memory port, requester and memory side
 */
`timescale 1ns/1ps
`default_nettype none

interface imem_bus_if;
    import fetch_pkg::*;

    logic   req;
    logic   we;
    addr_t  addr;
    instr_t wdata;
    // accept in the cycle where req and gnt are both high
    logic   gnt;
    // read data, one cycle after the accepted read
    instr_t rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport memory    (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// ==== src/imem_arbiter.sv ====
/*
 * fixed-priority memory arbiter, loader over fetch unit,
 * with read-owner tracking for the returned data
 */
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter (
    input  logic          clk_i,
    input  logic          rst_ni,
    imem_bus_if.memory    loader_bus,
    imem_bus_if.memory    fetch_bus,
    imem_bus_if.requester mem_bus
);

    logic loader_sel;
    // owner of the read whose data returns this cycle
    logic loader_rd_q;
    logic fetch_rd_q;

    // --------------------------------------------------
    // request select
    // --------------------------------------------------
    // loader wins whenever it asks
    assign loader_sel = loader_bus.req;

    assign mem_bus.req   = loader_bus.req | fetch_bus.req;
    assign mem_bus.we    = loader_sel ? loader_bus.we    : fetch_bus.we;
    assign mem_bus.addr  = loader_sel ? loader_bus.addr  : fetch_bus.addr;
    assign mem_bus.wdata = loader_sel ? loader_bus.wdata : fetch_bus.wdata;

    // fetch only gets through on an idle loader
    assign loader_bus.gnt = loader_bus.req & mem_bus.gnt;
    assign fetch_bus.gnt  = fetch_bus.req & ~loader_sel & mem_bus.gnt;

    // --------------------------------------------------
    // read data return
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            loader_rd_q <= 1'b0;
            fetch_rd_q  <= 1'b0;
        end else begin
            loader_rd_q <= loader_bus.gnt & ~loader_bus.we;
            fetch_rd_q  <= fetch_bus.gnt & ~fetch_bus.we;
        end
    end

    // only the owner sees the word
    assign loader_bus.rdata = loader_rd_q ? mem_bus.rdata : '0;
    assign fetch_bus.rdata  = fetch_rd_q  ? mem_bus.rdata : '0;

endmodule

`default_nettype wire

// ==== src/imem_sram.sv ====
/*
 * synchronous word memory, one-cycle read latency
 */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module imem_sram (
    input  logic       clk_i,
    imem_bus_if.memory mem_bus
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(`IMEM_WORDS);

    instr_t             mem_q [`IMEM_WORDS];
    instr_t             rdata_q;
    logic [IDX_W-1:0]   idx;

    // word index, byte offset dropped
    assign idx = mem_bus.addr[IDX_W+1:2];

    // never stalls
    assign mem_bus.gnt = mem_bus.req;

    always_ff @(posedge clk_i) begin
        if (mem_bus.req && mem_bus.we) begin
            mem_q[idx] <= mem_bus.wdata;
        end
        // read word held until the next read
        if (mem_bus.req && !mem_bus.we) begin
            rdata_q <= mem_q[idx];
        end
    end

    assign mem_bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
/*
 * program counter, read issue, access-fault entries,
 * static branch predecode and flush redirect
 */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   fetch_en_i,
    input  logic                   flush_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    imem_bus_if.requester          fetch_bus,
    input  logic                   fifo_ready_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                   entry_valid_o
);
    import fetch_pkg::*;

    localparam addr_t MEM_BYTES = addr_t'(`IMEM_WORDS * 4);

    addr_t       pc_q;
    // read response arrives this cycle
    logic        inflight_q;
    // fault entry goes out this cycle
    logic        fault_q;
    logic        busy;
    logic        in_range;
    logic        can_issue;

    instr_view_u view;
    logic        is_branch;
    logic        taken;
    addr_t       b_imm;
    addr_t       target;
    addr_t       next_pc;

    // --------------------------------------------------
    // request issue
    // --------------------------------------------------
    // one read or fault outstanding at most
    assign busy      = inflight_q | fault_q;
    assign in_range  = pc_q < MEM_BYTES;
    assign can_issue = fetch_en_i & fifo_ready_i & ~flush_i & ~busy;

    // out-of-range addresses never reach memory
    assign fetch_bus.req   = can_issue & in_range;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.addr  = pc_q;
    assign fetch_bus.wdata = '0;

    // --------------------------------------------------
    // predecode
    // --------------------------------------------------
    assign view.raw  = fetch_bus.rdata;
    assign is_branch = view.branch.opcode == OPCODE_BRANCH;
    // backward branch taken, forward not taken
    assign taken     = inflight_q & is_branch & view.branch.sign;
    // b immediate, sign bit is imm[12]
    assign b_imm     = {{20{view.branch.sign}}, view.branch.imm_11, view.branch.imm_10_5,
                        view.branch.imm_4_1, 1'b0};
    assign target    = pc_q + b_imm;
    assign next_pc   = taken ? target : pc_q + 32'd4;

    // --------------------------------------------------
    // entry out
    // --------------------------------------------------
    always_comb begin
        entry_o      = '0;
        entry_o.addr = pc_q;
        if (fault_q) begin
            entry_o.ex.valid = 1'b1;
            entry_o.ex.cause = CAUSE_ACCESS_FAULT;
        end else begin
            entry_o.instr     = view.raw;
            entry_o.bp.taken  = taken;
            entry_o.bp.target = taken ? target : '0;
        end
    end

    // a response during flush is dropped
    assign entry_valid_o = busy & ~flush_i;

    // --------------------------------------------------
    // pc and in-flight state
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q       <= `FETCH_RESET_PC;
            inflight_q <= 1'b0;
            fault_q    <= 1'b0;
        end else if (flush_i) begin
            // restart at redirect, pending work forgotten
            pc_q       <= redirect_pc_i;
            inflight_q <= 1'b0;
            fault_q    <= 1'b0;
        end else begin
            inflight_q <= fetch_bus.req & fetch_bus.gnt;
            // fault decided now, pushed next cycle like a read
            fault_q    <= can_issue & ~in_range;
            // pc holds the issued address until its entry leaves
            if (busy) begin
                pc_q <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_fifo.sv ====
/*
 * fetch fifo, circular buffer with early ready, flush, one read port
 */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_fifo (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // drops every stored entry
    input  logic                    flush_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    entry_valid_o,
    input  logic                    ack_i
);
    import fetch_pkg::*;

    localparam int unsigned DEPTH = `FETCH_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    // one slot kept free for the read in flight
    localparam logic [PTR_W:0] READY_MAX = (PTR_W + 1)'(DEPTH - 2);

    fetch_entry_t     mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   cnt_q;
    logic             push;
    logic             pop;

    // status
    assign ready_o       = cnt_q <= READY_MAX;
    assign entry_valid_o = cnt_q != '0;
    assign entry_o       = mem_q[rd_ptr_q];

    assign push = valid_i & ~flush_i;
    // ack only counts on a valid entry
    assign pop  = ack_i & entry_valid_o & ~flush_i;

    // --------------------------------------------------
    // pointers and count
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together keep the count
            cnt_q <= cnt_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/frontend_top.sv ====
/*
 * fetch frontend top: loader port, arbiter, sram, fetch unit, fifo
 */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // program loader, write only
    input  logic                    load_we_i,
    input  fetch_pkg::addr_t        load_addr_i,
    input  fetch_pkg::instr_t       load_data_i,
    // fetch control
    input  logic                    fetch_en_i,
    input  logic                    flush_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    // consumer side
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    entry_valid_o,
    input  logic                    entry_ack_i
);
    import fetch_pkg::*;

    fetch_entry_t fu_entry;
    logic         fu_valid;
    logic         fifo_ready;

    imem_bus_if loader_bus ();
    imem_bus_if fetch_bus ();
    imem_bus_if mem_bus ();

    // loader strobe is both request and write
    assign loader_bus.req   = load_we_i;
    assign loader_bus.we    = load_we_i;
    assign loader_bus.addr  = load_addr_i;
    assign loader_bus.wdata = load_data_i;

    // --------------------------------------------------
    // memory side
    // --------------------------------------------------
    imem_arbiter i_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .loader_bus (loader_bus),
        .fetch_bus  (fetch_bus),
        .mem_bus    (mem_bus)
    );

    imem_sram i_sram (
        .clk_i   (clk_i),
        .mem_bus (mem_bus)
    );

    // --------------------------------------------------
    // fetch path
    // --------------------------------------------------
    fetch_unit i_fetch_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_en_i    (fetch_en_i),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_bus     (fetch_bus),
        .fifo_ready_i  (fifo_ready),
        .entry_o       (fu_entry),
        .entry_valid_o (fu_valid)
    );

    fetch_fifo i_fetch_fifo (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .entry_i       (fu_entry),
        .valid_i       (fu_valid),
        .ready_o       (fifo_ready),
        .entry_o       (entry_o),
        .entry_valid_o (entry_valid_o),
        .ack_i         (entry_ack_i)
    );

endmodule

`default_nettype wire

// ==== verification/tb_frontend.sv ====
/*
 * testbench for the fetch frontend: program and phase tables,
 * reference model of the fetch sequence, entry compare tasks
 */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module tb_frontend;
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(`IMEM_WORDS);
    localparam addr_t MEM_BYTES = addr_t'(`IMEM_WORDS * 4);
    localparam int N_PROG  = 6;
    localparam int N_PHASE = 7;

    // program on top of the fill pattern
    localparam addr_t  PROG_ADDR  [N_PROG] = '{32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14};
    localparam instr_t PROG_INSTR [N_PROG] = '{
        32'h0010_0093,  // addi x1, x0, 1
        32'h0020_0113,  // addi x2, x0, 2
        32'h0020_8463,  // beq x1, x2, +8, forward
        32'h0010_8093,  // addi x1, x1, 1
        32'hFFF1_0113,  // addi x2, x2, -1, sign set but no branch
        32'hFE20_9CE3   // bne x1, x2, -8, backward to 0x0c
    };

    // one row of the control table
    typedef struct packed {
        int    cycles;
        int    ack_pct;
        logic  fetch_en;
        logic  flush;
        addr_t redirect;
        logic  load;
    } phase_t;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         load_we_i;
    addr_t        load_addr_i;
    instr_t       load_data_i;
    logic         fetch_en_i;
    logic         flush_i;
    addr_t        redirect_pc_i;
    fetch_entry_t entry_o;
    logic         entry_valid_o;
    logic         entry_ack_i;

    // model state: memory image and next fetch address
    instr_t       img [`IMEM_WORDS];
    addr_t        model_pc;
    phase_t       phases [N_PHASE];
    int           checks;
    int           errors;
    int           acked;
    int           taken_seen;
    int           fault_seen;

    always #20 clk_i = ~clk_i;

    frontend_top i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .fetch_en_i    (fetch_en_i),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .entry_o       (entry_o),
        .entry_valid_o (entry_valid_o),
        .entry_ack_i   (entry_ack_i)
    );

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    // inputs change 2 ns after the edge, strobes drop by default
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        entry_ack_i = 1'b0;
        load_we_i   = 1'b0;
        flush_i     = 1'b0;
    endtask

    task automatic load_word(input addr_t a, input instr_t d);
        load_we_i   = 1'b1;
        load_addr_i = a;
        load_data_i = d;
        img[a[IDX_W+1:2]] = d;
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    task automatic model_next(output fetch_entry_t e);
        instr_t w;
        addr_t  imm;
        e      = '0;
        e.addr = model_pc;
        if (model_pc >= MEM_BYTES) begin
            // access fault, nothing read
            e.ex.valid = 1'b1;
            e.ex.cause = 2'd1;
            model_pc   = model_pc + 32'd4;
        end else begin
            w       = img[model_pc[IDX_W+1:2]];
            e.instr = w;
            // b-type with negative offset is taken
            if (w[6:0] == 7'h63 && w[31]) begin
                imm         = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                e.bp.taken  = 1'b1;
                e.bp.target = model_pc + imm;
                model_pc    = model_pc + imm;
            end else begin
                model_pc = model_pc + 32'd4;
            end
        end
    endtask

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic addr_equal(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic instr_equal(input string name, input instr_t got, input instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic exc_equal(input string name, input exception_t got, input exception_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic flag_equal(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp);
        addr_equal("entry_o.addr", got.addr, exp.addr);
        instr_equal("entry_o.instr", got.instr, exp.instr);
        flag_equal("entry_o.bp.taken", got.bp.taken, exp.bp.taken);
        addr_equal("entry_o.bp.target", got.bp.target, exp.bp.target);
        exc_equal("entry_o.ex", got.ex, exp.ex);
    endtask

    // --------------------------------------------------
    // bounded waits
    // --------------------------------------------------
    task automatic wait_entry(input int limit);
        int n;
        n = 0;
        while (!entry_valid_o && n < limit) begin
            next_cycle();
            n++;
        end
        if (!entry_valid_o) begin
            errors++;
            $display("ERROR: no fetch entry showed up within %0d cycles", limit);
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (entry_valid_o && n < limit) begin
            next_cycle();
            n++;
        end
        if (entry_valid_o) begin
            errors++;
            $display("ERROR: entries still pending after fetch was disabled");
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int           p;
        int           load_idx;
        int           phase_acks;
        addr_t        a;
        fetch_entry_t exp_e;

        void'($urandom(65517));
        rst_ni        = 1'b0;
        load_we_i     = 1'b0;
        load_addr_i   = '0;
        load_data_i   = '0;
        fetch_en_i    = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        entry_ack_i   = 1'b0;
        model_pc      = `FETCH_RESET_PC;
        checks        = 0;
        errors        = 0;
        acked         = 0;
        taken_seen    = 0;
        fault_seen    = 0;
        load_idx      = 0;

        // cycles, ack %, fetch en, flush, redirect, loader writes
        phases[0] = '{40, 100, 1'b1, 1'b0, 32'h0, 1'b0};    // in order, branches
        phases[1] = '{30, 0, 1'b1, 1'b0, 32'h0, 1'b0};      // no ack, fifo full
        phases[2] = '{200, 30, 1'b1, 1'b0, 32'h0, 1'b1};    // random ack, loader busy
        phases[3] = '{300, 30, 1'b1, 1'b1, 32'h40, 1'b0};   // run off the end
        phases[4] = '{60, 50, 1'b1, 1'b1, 32'h200, 1'b0};   // redirect out of range
        phases[5] = '{60, 100, 1'b1, 1'b1, 32'h10, 1'b0};   // back into the loop
        phases[6] = '{30, 100, 1'b0, 1'b0, 32'h0, 1'b0};    // drain

        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        flag_equal("entry_valid_o", entry_valid_o, 1'b0);

        // fill depends on the address, program written over it
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            next_cycle();
            a = addr_t'(i * 4);
            load_word(a, {a[11:0], 20'h00013});
        end
        for (int i = 0; i < N_PROG; i++) begin
            next_cycle();
            load_word(PROG_ADDR[i], PROG_INSTR[i]);
        end
        next_cycle();
        next_cycle();
        flag_equal("entry_valid_o", entry_valid_o, 1'b0);

        for (p = 0; p < N_PHASE; p++) begin
            fetch_en_i = phases[p].fetch_en;
            if (phases[p].flush) begin
                // release any ack before the flush cycle
                next_cycle();
                flush_i       = 1'b1;
                redirect_pc_i = phases[p].redirect;
                model_pc      = phases[p].redirect;
                next_cycle();
            end
            if (phases[p].flush || p == 0) begin
                wait_entry(8);
            end
            phase_acks = 0;
            for (int c = 0; c < phases[p].cycles; c++) begin
                next_cycle();
                // loader writes to words not fetched in this phase
                if (phases[p].load && c % 16 == 5 && load_idx < 8) begin
                    a = addr_t'(32'hA0 + load_idx * 4);
                    load_word(a, {a[11:0], 20'h08093});
                    load_idx++;
                end
                if (entry_valid_o && ($urandom % 100) < phases[p].ack_pct) begin
                    entry_ack_i = 1'b1;
                    model_next(exp_e);
                    check_entry(entry_o, exp_e);
                    acked++;
                    phase_acks++;
                    if (exp_e.bp.taken) taken_seen++;
                    if (exp_e.ex.valid) fault_seen++;
                end
            end
            if (phase_acks == 0 && phases[p].ack_pct > 0 && phases[p].fetch_en) begin
                errors++;
                $display("ERROR: phase %0d delivered no entries", p);
            end
        end
        wait_drained(8);

        if (taken_seen == 0) begin
            errors++;
            $display("ERROR: no taken branch entry was delivered");
        end
        if (fault_seen == 0) begin
            errors++;
            $display("ERROR: no access fault entry was delivered");
        end
        $display("summary: %0d checks, %0d errors, %0d entries acked, %0d taken, %0d faults",
                 checks, errors, acked, taken_seen, fault_seen);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/fetch_pkg.sv
src/imem_bus_if.sv
src/imem_arbiter.sv
src/imem_sram.sv
src/fetch_unit.sv
src/fetch_fifo.sv
src/frontend_top.sv
verification/tb_frontend.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_frontend
FLIST    = flist.f

BUILD    = obj_dir
BIN      = $(BUILD)/$(TOP)
LOG      = sim.log
PASS_MSG = Verification passed
SRCS     = $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
